//--- common/fma_pkg.sv
`default_nettype none

package fma_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // operation codes
  // ~~~~~~~~~~~~~~~~~~~~

  // only FMADD is handled by this path, everything else reads as idle
  typedef enum logic [1:0] {
    OP_NONE  = 2'd0,
    OP_FMADD = 2'd1
  } op_e;

  // ~~~~~~~~~~~~~~~~~~~~
  // FIR field widths
  // ~~~~~~~~~~~~~~~~~~~~

  // total exponent, signed and unbiased
  localparam int TE_BITS = 8;

  // operand mantissa including the visible leading one
  localparam int MANT_SIZE = 8;

  // ~~~~~~~~~~~~~~~~~~~~
  // fixed-point format
  // ~~~~~~~~~~~~~~~~~~~~

  // FX_M integer bits including the sign, FX_B bits in total
  // the remaining FX_B-FX_M bits hold the fraction
  localparam int FX_M_DEFAULT = 31;
  localparam int FX_B_DEFAULT = 64;

  // ~~~~~~~~~~~~~~~~~~~~
  // field types
  // ~~~~~~~~~~~~~~~~~~~~

  // a FIR value is (-1)^sign * mant * 2^(exp - (width-1))
  typedef logic signed [TE_BITS-1:0] exp_t;

  // 1.fraction scaled by 2^(MANT_SIZE-1)
  typedef logic [MANT_SIZE-1:0] mant_t;

  // full product of two mantissas, scaled by 2^(2*MANT_SIZE-2)
  // the top bit is only set when the product of the two 1.f values reaches 2
  typedef logic [2*MANT_SIZE-1:0] prod_mant_t;

endpackage

`default_nettype wire

//--- hdl/fir_multiplier.sv
`timescale 1ns/100ps
`default_nettype none

module fir_multiplier (
  input  wire                      clk_i,
  input  wire                      reset_i,
  input  wire fma_pkg::op_e        op_i,

  input  wire                      a_sign_i,
  input  wire fma_pkg::exp_t       a_exp_i,
  input  wire fma_pkg::mant_t      a_mant_i,
  input  wire                      a_zero_i,

  input  wire                      b_sign_i,
  input  wire fma_pkg::exp_t       b_exp_i,
  input  wire fma_pkg::mant_t      b_mant_i,
  input  wire                      b_zero_i,

  input  wire                      c_sign_i,
  input  wire fma_pkg::exp_t       c_exp_i,
  input  wire fma_pkg::mant_t      c_mant_i,
  input  wire                      c_zero_i,

  output fma_pkg::op_e             op_o,
  output logic                     prod_sign_o,
  output fma_pkg::exp_t            prod_exp_o,
  output fma_pkg::prod_mant_t      prod_mant_o,
  output logic                     prod_zero_o,
  output logic                     add_sign_o,
  output fma_pkg::exp_t            add_exp_o,
  output fma_pkg::mant_t           add_mant_o,
  output logic                     add_zero_o
);

  fma_pkg::prod_mant_t prod_mant;
  fma_pkg::exp_t       prod_exp;

  // exponents add, the mantissa product keeps every bit
  assign prod_mant = fma_pkg::prod_mant_t'(a_mant_i) * fma_pkg::prod_mant_t'(b_mant_i);
  assign prod_exp  = a_exp_i + b_exp_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      op_o <= fma_pkg::OP_NONE;
    end else begin
      op_o <= op_i;
    end
  end

  always_ff @(posedge clk_i) begin
    prod_sign_o <= a_sign_i ^ b_sign_i;
    prod_exp_o  <= prod_exp;
    prod_mant_o <= prod_mant;
    prod_zero_o <= a_zero_i | b_zero_i;
    add_sign_o  <= c_sign_i;
    add_exp_o   <= c_exp_i;
    add_mant_o  <= c_mant_i;
    add_zero_o  <= c_zero_i;
  end

  // the addend is only consumed on the first cycle of a run, so it is only checked there
  a_norm_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (op_i == fma_pkg::OP_FMADD && !a_zero_i) |-> a_mant_i[fma_pkg::MANT_SIZE-1]);
  b_norm_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (op_i == fma_pkg::OP_FMADD && !b_zero_i) |-> b_mant_i[fma_pkg::MANT_SIZE-1]);
  c_norm_a: assert property (@(posedge clk_i) disable iff (reset_i)
    (op_i == fma_pkg::OP_FMADD && op_o != fma_pkg::OP_FMADD && !c_zero_i)
      |-> c_mant_i[fma_pkg::MANT_SIZE-1]);

endmodule

`default_nettype wire

//--- fma_accum/fir_to_fixed.sv
`timescale 1ns/100ps
`default_nettype none

module fir_to_fixed #(
  parameter int FRAC_SIZE = fma_pkg::MANT_SIZE,
  parameter int FX_M      = fma_pkg::FX_M_DEFAULT,
  parameter int FX_B      = fma_pkg::FX_B_DEFAULT
) (
  input  wire                      sign_i,
  input  wire fma_pkg::exp_t       exp_i,
  input  wire [FRAC_SIZE-1:0]      mant_i,
  input  wire                      zero_i,
  output logic [FX_B-1:0]          fixed_o
);

  // number of fraction bits in the fixed-point word
  localparam int FXF = FX_B - FX_M;

  // wide enough for the exponent plus any fixed-point offset
  localparam int SH_BITS = 16;

  logic signed [SH_BITS-1:0] shift;
  logic [SH_BITS-1:0]        shift_l;
  logic [SH_BITS-1:0]        shift_r;
  logic [FX_B-1:0]           mant_ext;
  logic [FX_B-1:0]           mag;

  // the leading one sits at bit FRAC_SIZE-1 and has to land at bit exp+FXF
  assign shift   = SH_BITS'(exp_i) + SH_BITS'(FXF - FRAC_SIZE + 1);
  assign shift_l = shift;
  assign shift_r = -shift;

  assign mant_ext = FX_B'(mant_i);

  // ~~~~~~~~~~~~~~~~~~~~
  // align and sign
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    // a right shift simply drops the bits below the LSB, so the magnitude truncates
    if (shift < 0) begin
      mag = mant_ext >> shift_r;
    end else begin
      mag = mant_ext << shift_l;
    end

    if (zero_i) begin
      fixed_o = '0;
    end else if (sign_i) begin
      fixed_o = -mag;
    end else begin
      fixed_o = mag;
    end
  end

endmodule

`default_nettype wire

//--- fma_accum/core_fma_accumulator.sv
`timescale 1ns/100ps
`default_nettype none

module core_fma_accumulator #(
  parameter int FX_M = fma_pkg::FX_M_DEFAULT,
  parameter int FX_B = fma_pkg::FX_B_DEFAULT
) (
  input  wire                      clk_i,
  input  wire                      reset_i,
  input  wire fma_pkg::op_e        op_i,

  input  wire                      prod_sign_i,
  input  wire fma_pkg::exp_t       prod_exp_i,
  input  wire fma_pkg::prod_mant_t prod_mant_i,
  input  wire                      prod_zero_i,

  input  wire                      add_sign_i,
  input  wire fma_pkg::exp_t       add_exp_i,
  input  wire fma_pkg::mant_t      add_mant_i,
  input  wire                      add_zero_i,

  output logic [FX_B-1:0]          acc_o,
  output logic [FX_B-1:0]          fixed_o,
  output logic                     done_o
);

  fma_pkg::op_e    op_st1;
  logic            fmadd;
  logic            start;
  fma_pkg::exp_t   prod_exp_adj;
  logic [FX_B-1:0] prod_fixed;
  logic [FX_B-1:0] add_fixed;
  logic [FX_B-1:0] acc_q;

  // ~~~~~~~~~~~~~~~~~~~~
  // run control
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      op_st1 <= fma_pkg::OP_NONE;
    end else begin
      op_st1 <= op_i;
    end
  end

  assign fmadd  = (op_i == fma_pkg::OP_FMADD);
  assign start  = fmadd && (op_st1 != fma_pkg::OP_FMADD);
  assign done_o = !fmadd && (op_st1 == fma_pkg::OP_FMADD);

  // ~~~~~~~~~~~~~~~~~~~~
  // operand conversion
  // ~~~~~~~~~~~~~~~~~~~~

  // the product mantissa is scaled by one power less than its width implies,
  // so its exponent moves up by one to fit the converter's 1.fraction form
  assign prod_exp_adj = prod_exp_i + fma_pkg::exp_t'(1);

  fir_to_fixed #(
    .FRAC_SIZE (2*fma_pkg::MANT_SIZE),
    .FX_M      (FX_M),
    .FX_B      (FX_B)
  ) u_prod_to_fixed (
    .sign_i    (prod_sign_i),
    .exp_i     (prod_exp_adj),
    .mant_i    (prod_mant_i),
    .zero_i    (prod_zero_i),
    .fixed_o   (prod_fixed)
  );

  fir_to_fixed #(
    .FRAC_SIZE (fma_pkg::MANT_SIZE),
    .FX_M      (FX_M),
    .FX_B      (FX_B)
  ) u_add_to_fixed (
    .sign_i    (add_sign_i),
    .exp_i     (add_exp_i),
    .mant_i    (add_mant_i),
    .zero_i    (add_zero_i),
    .fixed_o   (add_fixed)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // running sum
  // ~~~~~~~~~~~~~~~~~~~~

  // a new run overwrites the old sum, which has already been handed on in its done cycle
  always_ff @(posedge clk_i) begin
    if (start) begin
      acc_q <= add_fixed + prod_fixed;
    end else if (fmadd) begin
      acc_q <= acc_q + prod_fixed;
    end
  end

  assign acc_o   = acc_q;
  assign fixed_o = done_o ? acc_q : '0;

  fixed_quiet_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !done_o |-> (fixed_o == '0));
  start_done_a: assert property (@(posedge clk_i) disable iff (reset_i)
    !(start && done_o));

endmodule

`default_nettype wire

//--- hdl/fixed_to_fir.sv
`timescale 1ns/100ps
`default_nettype none

module fixed_to_fir #(
  parameter int FX_M = fma_pkg::FX_M_DEFAULT,
  parameter int FX_B = fma_pkg::FX_B_DEFAULT
) (
  input  wire                      clk_i,
  input  wire                      reset_i,
  input  wire [FX_B-1:0]           fixed_i,
  input  wire                      valid_i,
  output logic                     sign_o,
  output fma_pkg::exp_t            exp_o,
  output fma_pkg::mant_t           mant_o,
  output logic                     zero_o,
  output logic                     valid_o
);

  localparam int FXF      = FX_B - FX_M;
  localparam int POS_BITS = $clog2(FX_B);

  logic [FX_B-1:0]     mag;
  logic [POS_BITS-1:0] lead;
  logic [POS_BITS-1:0] norm_shift;
  logic [FX_B-1:0]     norm;
  fma_pkg::exp_t       exp_next;
  logic                zero_next;

  // the most negative sum still fits as an unsigned magnitude
  assign mag = fixed_i[FX_B-1] ? -fixed_i : fixed_i;

  // ~~~~~~~~~~~~~~~~~~~~
  // leading one
  // ~~~~~~~~~~~~~~~~~~~~

  // highest set bit wins since the scan runs upward
  always_comb begin
    lead = '0;
    for (int i = 0; i < FX_B; i++) begin
      if (mag[i]) begin
        lead = POS_BITS'(i);
      end
    end
  end

  // move the leading one to the top, the next bits below it form the mantissa
  assign norm_shift = POS_BITS'(FX_B - 1) - lead;
  assign norm       = mag << norm_shift;

  assign exp_next  = fma_pkg::exp_t'(int'(lead) - FXF);
  assign zero_next = (fixed_i == '0);

  // ~~~~~~~~~~~~~~~~~~~~
  // result register
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // the result holds until the next finished sum arrives
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      sign_o <= fixed_i[FX_B-1];
      exp_o  <= zero_next ? '0 : exp_next;
      mant_o <= norm[FX_B-1 -: fma_pkg::MANT_SIZE];
      zero_o <= zero_next;
    end
  end

endmodule

`default_nettype wire

//--- hdl/fma_unit_top.sv
`timescale 1ns/100ps
`default_nettype none

module fma_unit_top #(
  parameter int FX_M = fma_pkg::FX_M_DEFAULT,
  parameter int FX_B = fma_pkg::FX_B_DEFAULT
) (
  input  wire                      clk_i,
  input  wire                      reset_i,
  input  wire fma_pkg::op_e        op_i,

  input  wire                      a_sign_i,
  input  wire fma_pkg::exp_t       a_exp_i,
  input  wire fma_pkg::mant_t      a_mant_i,
  input  wire                      a_zero_i,

  input  wire                      b_sign_i,
  input  wire fma_pkg::exp_t       b_exp_i,
  input  wire fma_pkg::mant_t      b_mant_i,
  input  wire                      b_zero_i,

  input  wire                      c_sign_i,
  input  wire fma_pkg::exp_t       c_exp_i,
  input  wire fma_pkg::mant_t      c_mant_i,
  input  wire                      c_zero_i,

  output logic [FX_B-1:0]          fixed_o,
  output logic                     fixed_valid_o,
  output logic                     result_sign_o,
  output fma_pkg::exp_t            result_exp_o,
  output fma_pkg::mant_t           result_mant_o,
  output logic                     result_zero_o,
  output logic                     result_valid_o
);

  fma_pkg::op_e        op_m;
  logic                prod_sign;
  fma_pkg::exp_t       prod_exp;
  fma_pkg::prod_mant_t prod_mant;
  logic                prod_zero;
  logic                add_sign;
  fma_pkg::exp_t       add_exp;
  fma_pkg::mant_t      add_mant;
  logic                add_zero;
  logic [FX_B-1:0]     acc;

  // ~~~~~~~~~~~~~~~~~~~~
  // multiply stage
  // ~~~~~~~~~~~~~~~~~~~~

  fir_multiplier u_multiplier (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .op_i        (op_i),
    .a_sign_i    (a_sign_i),
    .a_exp_i     (a_exp_i),
    .a_mant_i    (a_mant_i),
    .a_zero_i    (a_zero_i),
    .b_sign_i    (b_sign_i),
    .b_exp_i     (b_exp_i),
    .b_mant_i    (b_mant_i),
    .b_zero_i    (b_zero_i),
    .c_sign_i    (c_sign_i),
    .c_exp_i     (c_exp_i),
    .c_mant_i    (c_mant_i),
    .c_zero_i    (c_zero_i),
    .op_o        (op_m),
    .prod_sign_o (prod_sign),
    .prod_exp_o  (prod_exp),
    .prod_mant_o (prod_mant),
    .prod_zero_o (prod_zero),
    .add_sign_o  (add_sign),
    .add_exp_o   (add_exp),
    .add_mant_o  (add_mant),
    .add_zero_o  (add_zero)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // accumulate stage
  // ~~~~~~~~~~~~~~~~~~~~

  // the done strobe doubles as the raw sum valid and the normalizer load
  core_fma_accumulator #(
    .FX_M        (FX_M),
    .FX_B        (FX_B)
  ) u_accumulator (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .op_i        (op_m),
    .prod_sign_i (prod_sign),
    .prod_exp_i  (prod_exp),
    .prod_mant_i (prod_mant),
    .prod_zero_i (prod_zero),
    .add_sign_i  (add_sign),
    .add_exp_i   (add_exp),
    .add_mant_i  (add_mant),
    .add_zero_i  (add_zero),
    .acc_o       (acc),
    .fixed_o     (fixed_o),
    .done_o      (fixed_valid_o)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // normalize stage
  // ~~~~~~~~~~~~~~~~~~~~

  fixed_to_fir #(
    .FX_M        (FX_M),
    .FX_B        (FX_B)
  ) u_normalizer (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .fixed_i     (acc),
    .valid_i     (fixed_valid_o),
    .sign_o      (result_sign_o),
    .exp_o       (result_exp_o),
    .mant_o      (result_mant_o),
    .zero_o      (result_zero_o),
    .valid_o     (result_valid_o)
  );

endmodule

`default_nettype wire

//--- bench/fma_unit_tb.sv
`timescale 1ns/100ps
`default_nettype none

module fma_unit_tb;

  localparam int FX_M    = fma_pkg::FX_M_DEFAULT;
  localparam int FX_B    = fma_pkg::FX_B_DEFAULT;
  localparam int FXF     = FX_B - FX_M;
  localparam int MS      = fma_pkg::MANT_SIZE;
  localparam int TIMEOUT = 40;

  typedef struct packed {
    logic           zero;
    logic           sign;
    fma_pkg::exp_t  expo;
    fma_pkg::mant_t mant;
  } fir_t;

  logic            clk;
  logic            reset;
  fma_pkg::op_e    op;
  logic            a_sign, a_zero, b_sign, b_zero, c_sign, c_zero;
  fma_pkg::exp_t   a_exp, b_exp, c_exp;
  fma_pkg::mant_t  a_mant, b_mant, c_mant;
  logic [FX_B-1:0] fixed_o;
  logic            fixed_valid_o;
  logic            result_sign_o;
  fma_pkg::exp_t   result_exp_o;
  fma_pkg::mant_t  result_mant_o;
  logic            result_zero_o;
  logic            result_valid_o;

  // expected raw sums in run order, and the sum whose normalized form is due next cycle
  logic [FX_B-1:0] sum_q[$];
  logic [FX_B-1:0] model_sum;
  logic [FX_B-1:0] norm_sum;
  logic            norm_due;
  int              pending;
  int unsigned     seed;

  fma_unit_top u_dut (
    .clk_i          (clk),
    .reset_i        (reset),
    .op_i           (op),
    .a_sign_i       (a_sign),
    .a_exp_i        (a_exp),
    .a_mant_i       (a_mant),
    .a_zero_i       (a_zero),
    .b_sign_i       (b_sign),
    .b_exp_i        (b_exp),
    .b_mant_i       (b_mant),
    .b_zero_i       (b_zero),
    .c_sign_i       (c_sign),
    .c_exp_i        (c_exp),
    .c_mant_i       (c_mant),
    .c_zero_i       (c_zero),
    .fixed_o        (fixed_o),
    .fixed_valid_o  (fixed_valid_o),
    .result_sign_o  (result_sign_o),
    .result_exp_o   (result_exp_o),
    .result_mant_o  (result_mant_o),
    .result_zero_o  (result_zero_o),
    .result_valid_o (result_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // checking
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic fail_now(string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_equal(string name, logic [FX_B-1:0] got, logic [FX_B-1:0] expected);
    if (got !== expected) begin
      fail_now($sformatf("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, expected));
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // reference model
  // ~~~~~~~~~~~~~~~~~~~~

  // mag * 2^pow in the fixed-point grid, truncated toward zero before the sign is applied
  function automatic logic [FX_B-1:0] scaled(logic neg, longint unsigned mag, int pow);
    logic [FX_B-1:0] v;
    v = mag;
    if (pow + FXF >= 0) begin
      v = v << (pow + FXF);
    end else begin
      v = v >> (-(pow + FXF));
    end
    return neg ? -v : v;
  endfunction

  function automatic logic [FX_B-1:0] prod_fixed(fir_t a, fir_t b);
    longint unsigned m;
    m = a.mant;
    m = m * b.mant;
    if (a.zero || b.zero) begin
      return '0;
    end
    return scaled(a.sign ^ b.sign, m, int'(a.expo) + int'(b.expo) - 2*(MS-1));
  endfunction

  function automatic logic [FX_B-1:0] addend_fixed(fir_t c);
    if (c.zero) begin
      return '0;
    end
    return scaled(c.sign, c.mant, int'(c.expo) - (MS-1));
  endfunction

  task automatic check_result(logic [FX_B-1:0] sum);
    logic [FX_B-1:0] mag;
    logic [FX_B-1:0] mant;
    int              lead;
    mag  = sum[FX_B-1] ? -sum : sum;
    lead = 0;
    for (int i = 0; i < FX_B; i++) begin
      if (mag[i]) begin
        lead = i;
      end
    end
    // the mantissa is the leading one and the bits right below it
    if (lead >= MS-1) begin
      mant = mag >> (lead - (MS-1));
    end else begin
      mant = mag << ((MS-1) - lead);
    end
    check_equal("result_zero_o", FX_B'(result_zero_o), FX_B'(sum == '0));
    check_equal("result_sign_o", FX_B'(result_sign_o), FX_B'(sum[FX_B-1]));
    if (sum != '0) begin
      check_equal("result_exp_o", FX_B'(result_exp_o), FX_B'(fma_pkg::exp_t'(lead - FXF)));
      check_equal("result_mant_o", FX_B'(result_mant_o), FX_B'(mant[MS-1:0]));
    end
  endtask

  // the raw sum arrives in the done cycle and its normalized form exactly one cycle later
  always @(negedge clk) begin
    if (!reset) begin
      if (norm_due) begin
        if (!result_valid_o) begin
          fail_now("the result strobe did not follow the raw sum strobe by one cycle");
        end else begin
          check_result(norm_sum);
          pending--;
        end
      end else if (result_valid_o) begin
        fail_now("result strobe seen without a finished sum before it");
      end
      norm_due = 1'b0;
      if (fixed_valid_o) begin
        if (sum_q.size() == 0) begin
          fail_now("raw sum strobe seen with no run outstanding");
        end else begin
          norm_sum = sum_q.pop_front();
          check_equal("fixed_o", fixed_o, norm_sum);
          norm_due = 1'b1;
        end
      end else begin
        check_equal("fixed_o", fixed_o, '0);
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // stimulus
  // ~~~~~~~~~~~~~~~~~~~~

  function automatic fir_t fir(logic z, logic s, int e, int m);
    fir_t f;
    f.zero = z;
    f.sign = s;
    f.expo = fma_pkg::exp_t'(e);
    f.mant = fma_pkg::mant_t'(m);
    return f;
  endfunction

  // small normalized operands so that every sum fits the integer part
  function automatic fir_t rand_fir();
    return fir(1'b0, 1'($urandom % 2), int'($urandom % 13) - 6, 128 + int'($urandom % 128));
  endfunction

  task automatic fmadd_step(fir_t a, fir_t b, fir_t c, logic first);
    @(posedge clk);
    op     <= fma_pkg::OP_FMADD;
    a_sign <= a.sign;
    a_exp  <= a.expo;
    a_mant <= a.mant;
    a_zero <= a.zero;
    b_sign <= b.sign;
    b_exp  <= b.expo;
    b_mant <= b.mant;
    b_zero <= b.zero;
    c_sign <= c.sign;
    c_exp  <= c.expo;
    c_mant <= c.mant;
    c_zero <= c.zero;
    if (first) begin
      model_sum = addend_fixed(c) + prod_fixed(a, b);
    end else begin
      model_sum = model_sum + prod_fixed(a, b);
    end
  endtask

  task automatic finish_run();
    @(posedge clk);
    op <= fma_pkg::OP_NONE;
    sum_q.push_back(model_sum);
    pending++;
  endtask

  // called right after the edge that drives op_i idle
  // the raw sum strobe is low in the next cycle and high in the one after
  task automatic expect_sum_strobe();
    @(negedge clk);
    check_equal("fixed_valid_o", FX_B'(fixed_valid_o), '0);
    @(negedge clk);
    check_equal("fixed_valid_o", FX_B'(fixed_valid_o), FX_B'(1'b1));
  endtask

  task automatic random_run(int n);
    for (int i = 0; i < n; i++) begin
      fmadd_step(rand_fir(), rand_fir(), rand_fir(), i == 0);
    end
    finish_run();
  endtask

  task automatic wait_results();
    int cycles;
    cycles = 0;
    while (pending != 0) begin
      if (cycles == TIMEOUT) begin
        fail_now("timed out waiting for the sum and result strobes");
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // tests
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic test_idle();
    repeat (6) begin
      @(negedge clk);
      check_equal("fixed_valid_o", FX_B'(fixed_valid_o), '0);
      check_equal("result_valid_o", FX_B'(result_valid_o), '0);
    end
  endtask

  task automatic test_single();
    fmadd_step(fir(0, 0, 1, 8'hA0), fir(0, 1, 0, 8'hC0), fir(0, 0, 2, 8'h90), 1'b1);
    finish_run();
    expect_sum_strobe();
    wait_results();
    fmadd_step(fir(0, 1, 3, 8'hFF), fir(0, 0, 2, 8'h81), fir(0, 0, -1, 8'h80), 1'b1);
    finish_run();
    expect_sum_strobe();
    wait_results();
  endtask

  task automatic test_random_runs();
    repeat (5) begin
      random_run(2 + int'($urandom % 7));
      wait_results();
    end
  endtask

  // exactly one idle cycle separates the two runs
  task automatic test_back_to_back();
    random_run(2 + int'($urandom % 7));
    random_run(2 + int'($urandom % 7));
    wait_results();
  endtask

  task automatic test_zero_trunc();
    // zero operands carry a stale mantissa that only the zero flag masks
    fmadd_step(rand_fir(), fir(1, 0, 0, 8'hC0), fir(1, 1, 2, 8'hA0), 1'b1);
    fmadd_step(fir(1, 0, 0, 8'hB0), rand_fir(), rand_fir(), 1'b0);
    fmadd_step(rand_fir(), rand_fir(), rand_fir(), 1'b0);
    finish_run();
    wait_results();
    // one times one minus one
    fmadd_step(fir(0, 0, 0, 8'h80), fir(0, 0, 0, 8'h80), fir(0, 1, 0, 8'h80), 1'b1);
    finish_run();
    wait_results();
    fmadd_step(fir(0, 0, -12, 8'hFF), fir(0, 1, -12, 8'hFF), fir(0, 1, -30, 8'hC3), 1'b1);
    fmadd_step(fir(0, 0, -12, 8'hB7), fir(0, 0, -13, 8'h9D), rand_fir(), 1'b0);
    finish_run();
    wait_results();
  endtask

  initial begin
    seed      = $urandom(2);
    reset     = 1'b1;
    op        = fma_pkg::OP_NONE;
    {a_sign, a_exp, a_mant, a_zero} = {1'b0, 8'sd0, 8'h00, 1'b1};
    {b_sign, b_exp, b_mant, b_zero} = {1'b0, 8'sd0, 8'h00, 1'b1};
    {c_sign, c_exp, c_mant, c_zero} = {1'b0, 8'sd0, 8'h00, 1'b1};
    model_sum = '0;
    norm_sum  = '0;
    norm_due  = 1'b0;
    pending   = 0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    test_idle();
    test_single();
    test_random_runs();
    test_back_to_back();
    test_zero_trunc();
    repeat (3) @(posedge clk);
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
common/fma_pkg.sv
hdl/fir_multiplier.sv
fma_accum/fir_to_fixed.sv
fma_accum/core_fma_accumulator.sv
hdl/fixed_to_fir.sv
hdl/fma_unit_top.sv
bench/fma_unit_tb.sv

//--- Makefile
SRCS := $(shell cat vlog.f)

.PHONY: all run clean

all: obj_dir/Vfma_unit_tb

obj_dir/Vfma_unit_tb: vlog.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f vlog.f \
		--top-module fma_unit_tb -o Vfma_unit_tb

run: obj_dir/Vfma_unit_tb
	./obj_dir/Vfma_unit_tb

clean:
	rm -rf obj_dir
